// ==== all.f ====
vshift_pkg.sv
byte_lane_shifter.sv
vector_shifter.sv
beat_fifo.sv
beat_counter.sv
shift_ctrl_fsm.sv
vshift_unit.sv
tb_clk_gen.sv
tb_vshift.sv

// ==== beat_counter.sv ====
//******************************
// Beat counter
// Counts the beats of a command down to zero
//******************************

module beat_counter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              load,
    input  logic [vshift_pkg::BEAT_CNT_W-1:0] load_value,
    input  logic                              dec,
    output logic                              last_beat,
    output logic                              done
);

    logic [vshift_pkg::BEAT_CNT_W-1:0] remaining;  // Beats still to issue

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= load_value;
        end else if (dec) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign last_beat = (remaining == 1);
    assign done      = (remaining == '0);

    a_no_dec_at_zero: assert property (@(posedge clk) disable iff (!rst_n) dec |-> !done)
        else $error("beat_counter decrement at zero");

    // A fresh command must bring at least one beat
    a_load_nonzero: assert property (@(posedge clk) disable iff (!rst_n) load |=> !done)
        else $error("beat_counter loaded with zero beats");

endmodule : beat_counter

// ==== beat_fifo.sv ====
//******************************
// Beat FIFO
// Register array FIFO for any payload type
//******************************

module beat_fifo #(
    parameter int  DEPTH     = 2,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);  // Both in one cycle keeps the level
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_data;
    end

    assign pop_data = mem[rd_ptr];
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);

    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("beat_fifo push while full");
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("beat_fifo pop while empty");

endmodule : beat_fifo

// ==== byte_lane_shifter.sv ====
//******************************
// Byte lane shifter
// Shifts one byte by 0 to 7 bits, filling
// from a neighbour byte or with sign/zero
//******************************

module byte_lane_shifter (
    input  logic [vshift_pkg::BYTE_WIDTH-1:0]         src,
    input  logic [$clog2(vshift_pkg::BYTE_WIDTH)-1:0] amount,
    input  logic                                      shift_left,
    input  logic                                      arith,
    input  logic [vshift_pkg::BYTE_WIDTH-1:0]         carry_in,
    output logic [vshift_pkg::BYTE_WIDTH-1:0]         result
);

    localparam int BW = vshift_pkg::BYTE_WIDTH;

    logic [BW-1:0]   fill;
    logic [2*BW-1:0] left_pair;
    logic [2*BW-1:0] right_pair;

    // Top byte of an arithmetic shift takes its own sign bit
    assign fill = arith ? {BW{src[BW-1]}} : carry_in;

    // Neighbour sits below for left shifts and above for right shifts
    assign left_pair  = {src, fill} << amount;
    assign right_pair = {fill, src} >> amount;

    always_comb begin
        if (shift_left) begin
            result = left_pair[2*BW-1:BW];  // Upper half after shift
        end else begin
            result = right_pair[BW-1:0];
        end
    end

endmodule : byte_lane_shifter

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the vector shift unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_vshift -f all.f -o Vtb_vshift; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_vshift > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

exit 0

// ==== shift_ctrl_fsm.sv ====
//******************************
// Shift control FSM
// Accepts a command, issues its beats into
// the shifter and closes after the last result
//******************************

module shift_ctrl_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  vshift_pkg::cmd_t      cmd,
    input  logic                  in_empty,
    input  logic                  out_full,
    input  logic                  count_done,
    input  logic                  last_result_sent,
    output logic                  accept_beats,
    output logic                  issue,
    output logic                  load,
    output vshift_pkg::shift_op_e cur_op,
    output vshift_pkg::sew_e      cur_sew
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_e;

    state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else if (state == ST_IDLE) begin
            if (load) state <= ST_BUSY;
        end else if (last_result_sent) begin
            state <= ST_IDLE;  // Last result has left the unit
        end
    end

    // Operation stays fixed for the whole command
    always_ff @(posedge clk) begin
        if (load) begin
            cur_op  <= cmd.op;
            cur_sew <= cmd.sew;
        end
    end

    assign cmd_ready    = (state == ST_IDLE);
    assign load         = cmd_valid & cmd_ready;
    assign accept_beats = (state == ST_BUSY) & ~count_done;

    // Pop input and push output together
    assign issue = ~in_empty & ~out_full & ~count_done;

    a_no_issue_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_IDLE) |-> !issue)
        else $error("shift_ctrl_fsm issue while idle");

    // The last result can only leave once every beat was issued
    a_close_after_count: assert property (@(posedge clk) disable iff (!rst_n)
        last_result_sent |-> (state == ST_BUSY) && count_done)
        else $error("shift_ctrl_fsm closed before all beats issued");

endmodule : shift_ctrl_fsm

// ==== tb_clk_gen.sv ====
//******************************
// Testbench clock and reset
//******************************

module tb_clk_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule : tb_clk_gen

// ==== tb_vshift.sv ====
//******************************
// Vector shift unit testbench
// Directed shift tests, stream handshakes,
// back-pressure, reference model checks
//******************************

module tb_vshift;

    localparam int DW          = vshift_pkg::DATA_WIDTH;
    localparam int CNT_W       = vshift_pkg::BEAT_CNT_W;
    localparam int LEFT_BEATS  = 4 * 5;        // Four widths, five beats each
    localparam int RIGHT_BEATS = 2 * 4 * 5;
    localparam int MULTI_BEATS = 12;
    localparam int BP_BEATS    = 10 + 16;
    localparam int TOTAL_BEATS = LEFT_BEATS + RIGHT_BEATS + MULTI_BEATS + BP_BEATS;

    logic                clk;
    logic                rst_n;
    logic                cmd_valid;
    logic                cmd_ready;
    vshift_pkg::cmd_t    cmd;
    logic                in_valid;
    logic                in_ready;
    vshift_pkg::beat_t   in_beat;
    logic                out_valid;
    logic                out_ready;
    vshift_pkg::result_t out_result;

    vshift_pkg::beat_t   beat_q[$];  // Beats of the next command
    vshift_pkg::result_t exp_q[$];
    int                  seed;

    tb_clk_gen #(.PERIOD(10), .RESET_CYCLES(5)) u_clk_gen (.clk(clk), .rst_n(rst_n));

    vshift_unit #(.FIFO_DEPTH(2)) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    task automatic stop_with_failure();
        $display("TESTBENCH FAILED");
        $fatal(1, "first error reached");
    endtask

    task automatic check_result(input string name, input vshift_pkg::result_t got,
                                input vshift_pkg::result_t want);
        if (got !== want) begin
            $display("Fail %s: data %h last %h, expected data %h last %h",
                     name, got.data, got.last, want.data, want.last);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            stop_with_failure();
        end
    endtask

    // Element by element model, amount taken modulo the element width
    function automatic logic [DW-1:0] ref_shift(input vshift_pkg::shift_op_e op,
                                                input vshift_pkg::sew_e sew,
                                                input logic [DW-1:0] a,
                                                input logic [DW-1:0] b);
        int                 ew;
        int                 amt;
        logic [DW-1:0]      mask;
        logic [DW-1:0]      elem;
        logic [DW-1:0]      res;
        logic signed [DW-1:0] selem;
        ew   = 8 << int'(sew);
        mask = (ew == DW) ? '1 : (64'd1 << ew) - 64'd1;
        res  = '0;
        for (int e = 0; e < DW / ew; e++) begin
            elem = (a >> (e * ew)) & mask;
            amt  = int'((b >> (e * ew)) & 64'(ew - 1));
            case (op)
                vshift_pkg::SHIFT_SLL: elem = (elem << amt) & mask;
                vshift_pkg::SHIFT_SRL: elem = elem >> amt;
                default: begin
                    selem = elem[ew-1] ? (elem | ~mask) : elem;  // Sign extend first
                    selem = selem >>> amt;
                    elem  = selem & mask;
                end
            endcase
            res = res | (elem << (e * ew));
        end
        return res;
    endfunction

    function automatic logic [DW-1:0] rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    task automatic add_beat(input logic [DW-1:0] a, input logic [DW-1:0] b);
        vshift_pkg::beat_t beat;
        beat.srca = a;
        beat.srcb = b;
        beat_q.push_back(beat);
    endtask

    task automatic add_random_beat();
        logic [DW-1:0] a;
        logic [DW-1:0] b;
        a = rand64();
        b = rand64();
        add_beat(a, b);
    endtask

    // Command first, then every beat of beat_q
    task automatic send_stream(input vshift_pkg::cmd_t c, input bit gaps);
        bit taken;
        int gap;
        cmd       = c;
        cmd_valid = 1'b1;
        do begin
            taken = cmd_ready;
            @(negedge clk);
        end while (!taken);
        cmd_valid = 1'b0;
        check_flag("cmd_ready", cmd_ready, 1'b0);  // Busy with this command
        foreach (beat_q[i]) begin
            gap = gaps ? (i * 7) % 4 : 0;
            repeat (gap) @(negedge clk);
            in_beat  = beat_q[i];
            in_valid = 1'b1;
            do begin
                taken = in_ready;
                @(negedge clk);
            end while (!taken);
            in_valid = 1'b0;
        end
    endtask

    task automatic collect_results(input bit random_ready, input int stall);
        int got;
        got       = 0;
        out_ready = 1'b0;
        repeat (stall) @(negedge clk);
        if (stall > 0) begin
            // Both FIFOs full while the output is held
            check_flag("in_ready", in_ready, 1'b0);
            check_flag("out_valid", out_valid, 1'b1);
        end
        while (got < exp_q.size()) begin
            out_ready = random_ready ? 1'($random(seed)) : 1'b1;
            if (out_valid && out_ready) begin
                check_result($sformatf("out_result[%0d]", got), out_result, exp_q[got]);
                got++;
            end
            @(negedge clk);
        end
        out_ready = 1'b0;
    endtask

    task automatic run_command(input vshift_pkg::shift_op_e op, input vshift_pkg::sew_e sew,
                               input bit gaps, input bit random_ready, input int stall);
        vshift_pkg::cmd_t    c;
        vshift_pkg::result_t want;
        exp_q.delete();
        foreach (beat_q[i]) begin
            want.data = ref_shift(op, sew, beat_q[i].srca, beat_q[i].srcb);
            want.last = (i == beat_q.size() - 1);
            exp_q.push_back(want);
        end
        c.op        = op;
        c.sew       = sew;
        c.num_beats = CNT_W'(beat_q.size());
        fork
            send_stream(c, gaps);
            collect_results(random_ready, stall);
        join
        check_flag("cmd_ready", cmd_ready, 1'b1);
        check_flag("in_ready", in_ready, 1'b0);    // No beat beyond num_beats
        check_flag("out_valid", out_valid, 1'b0);
    endtask

    task automatic test_reset_state();
        check_flag("cmd_ready", cmd_ready, 1'b1);
        check_flag("in_ready", in_ready, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
    endtask

    task automatic test_left_shifts();
        for (int k = 0; k < 4; k++) begin
            beat_q.delete();
            add_beat(64'h0123_4567_89ab_cdef, 64'h0);
            add_beat(64'h0123_4567_89ab_cdef, 64'h0706_0504_0302_0100);
            add_beat(64'hf00f_a55a_8001_7ffe, 64'h3f41_2019_1810_0f09);  // Wraps past width
            add_beat(64'hffff_0000_ffff_0001, 64'hffff_ffff_ffff_ffff);
            add_random_beat();
            run_command(vshift_pkg::SHIFT_SLL, vshift_pkg::sew_e'(k), 1'b0, 1'b0, 0);
        end
    endtask

    task automatic test_right_shifts();
        vshift_pkg::shift_op_e op;
        for (int o = 0; o < 2; o++) begin
            op = o ? vshift_pkg::SHIFT_SRA : vshift_pkg::SHIFT_SRL;
            for (int k = 0; k < 4; k++) begin
                beat_q.delete();
                add_beat(64'hf08f_c3a5_81ff_9c80, 64'h0);                // Every element negative
                add_beat(64'hf08f_c3a5_81ff_9c80, 64'h0706_0504_0302_0100);
                add_beat(64'hfedc_ba98_f6e5_d4c3, 64'h3f41_2019_1810_0f09);
                add_beat(64'h7f80_00ff_4001_8000, 64'hffff_ffff_ffff_ffff);
                add_random_beat();
                run_command(op, vshift_pkg::sew_e'(k), 1'b0, 1'b0, 0);
            end
        end
    endtask

    task automatic test_multi_beat();
        beat_q.delete();
        repeat (MULTI_BEATS) add_random_beat();
        run_command(vshift_pkg::SHIFT_SRA, vshift_pkg::SEW_16, 1'b0, 1'b0, 0);
    endtask

    task automatic test_back_pressure();
        beat_q.delete();
        repeat (10) add_random_beat();
        run_command(vshift_pkg::SHIFT_SLL, vshift_pkg::SEW_32, 1'b0, 1'b0, 12);
        beat_q.delete();
        repeat (16) add_random_beat();
        run_command(vshift_pkg::SHIFT_SRA, vshift_pkg::SEW_8, 1'b1, 1'b1, 0);
    endtask

    // Limit scales with the number of beats in all tests
    initial begin : watchdog
        repeat (TOTAL_BEATS * 20) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", TOTAL_BEATS * 20);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed      = 32'hf4c6;
        cmd_valid = 1'b0;
        cmd       = '0;
        in_valid  = 1'b0;
        in_beat   = '0;
        out_ready = 1'b0;
        @(posedge rst_n);
        @(negedge clk);
        test_reset_state();
        test_left_shifts();
        test_right_shifts();
        test_multi_beat();
        test_back_pressure();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule : tb_vshift

// ==== vector_shifter.sv ====
//******************************
// Vector shifter
// Byte move network plus byte lane bit shift
// for 8/16/32/64-bit elements of one beat
//******************************

module vector_shifter (
    input  vshift_pkg::shift_op_e               op,
    input  vshift_pkg::sew_e                    sew,
    input  logic [vshift_pkg::DATA_WIDTH-1:0]   srca,
    input  logic [vshift_pkg::DATA_WIDTH-1:0]   srcb,
    output logic [vshift_pkg::DATA_WIDTH-1:0]   result
);

    localparam int N          = vshift_pkg::VSHIFT_BYTES;
    localparam int BW         = vshift_pkg::BYTE_WIDTH;
    localparam int BIT_SEL_W  = $clog2(BW);
    localparam int BYTE_SEL_W = $clog2(N);
    localparam int AMT_W      = BIT_SEL_W + BYTE_SEL_W;

    vshift_pkg::byte_vec_t a_bytes;
    vshift_pkg::byte_vec_t b_bytes;
    vshift_pkg::byte_vec_t a_lane;     // Lane order, reversed for left shifts
    vshift_pkg::byte_vec_t stage [BYTE_SEL_W+1];
    vshift_pkg::byte_vec_t moved;
    vshift_pkg::byte_vec_t carry;
    vshift_pkg::byte_vec_t lane_out;
    vshift_pkg::byte_vec_t res_bytes;

    logic [AMT_W-1:0]      amt_orig [N];
    logic [AMT_W-1:0]      amt_lane [N];
    logic [N-1:0]          lane_arith;
    logic [BYTE_SEL_W-1:0] e_mask;     // Element size in bytes minus one
    logic [AMT_W-1:0]      amt_mask;   // Amount modulo element width
    logic                  is_left;
    logic                  is_arith;

    assign is_left  = (op == vshift_pkg::SHIFT_SLL);
    assign is_arith = (op == vshift_pkg::SHIFT_SRA);
    assign e_mask   = BYTE_SEL_W'((1 << sew) - 1);
    assign amt_mask = {e_mask, {BIT_SEL_W{1'b1}}};
    assign a_bytes  = srca;
    assign b_bytes  = srcb;

    always_comb begin : shift_net
        int base;
        int top;
        int src_idx;
        logic at_top;
        logic [BW-1:0] fill;

        // Each element shifts by its own lowest byte
        for (int i = 0; i < N; i++) begin
            base        = i - (i & e_mask);
            amt_orig[i] = b_bytes[base][AMT_W-1:0] & amt_mask;
        end

        // One right-oriented network serves both directions
        for (int j = 0; j < N; j++) begin
            a_lane[j]   = is_left ? a_bytes[N-1-j] : a_bytes[j];
            amt_lane[j] = is_left ? amt_orig[N-1-j] : amt_orig[j];
        end

        // Whole byte moves by 1, 2 then 4 bytes, kept inside the element
        stage[0] = a_lane;
        for (int s = 0; s < BYTE_SEL_W; s++) begin
            for (int j = 0; j < N; j++) begin
                top     = j | e_mask;
                src_idx = (j + (1 << s)) % N;
                fill    = {BW{is_arith & a_lane[top][BW-1]}};  // Sign byte or zero
                if (amt_lane[j][BIT_SEL_W+s]) begin
                    if ((j & e_mask) + (1 << s) <= e_mask) begin
                        stage[s+1][j] = stage[s][src_idx];
                    end else begin
                        stage[s+1][j] = fill;
                    end
                end else begin
                    stage[s+1][j] = stage[s][j];
                end
            end
        end
        moved = stage[BYTE_SEL_W];

        // Carries only from the next byte of the same element
        for (int j = 0; j < N; j++) begin
            at_top        = ((j & e_mask) == e_mask);
            src_idx       = (j + 1) % N;
            carry[j]      = at_top ? '0 : moved[src_idx];
            lane_arith[j] = at_top & is_arith;
        end
    end

    for (genvar g = 0; g < N; g++) begin : gen_lane
        byte_lane_shifter u_lane (
            .src        (moved[g]),
            .amount     (amt_lane[g][BIT_SEL_W-1:0]),
            .shift_left (is_left),
            .arith      (lane_arith[g]),
            .carry_in   (carry[g]),
            .result     (lane_out[g])
        );
    end

    // Undo the lane reversal
    always_comb begin
        for (int i = 0; i < N; i++) begin
            res_bytes[i] = is_left ? lane_out[N-1-i] : lane_out[i];
        end
    end

    assign result = res_bytes;

endmodule : vector_shifter

// ==== vshift_pkg.sv ====
//******************************
// Vector shift unit package
// Width constants, operation and element width
// enums, stream structs shared by the unit
//******************************

package vshift_pkg;

    // Beat geometry
    localparam int VSHIFT_BYTES = 8;
    localparam int BYTE_WIDTH   = 8;
    localparam int DATA_WIDTH   = VSHIFT_BYTES * BYTE_WIDTH;  // 64-bit beat

    // Up to 255 beats per command
    localparam int BEAT_CNT_W = 8;

    // Shift operation
    typedef enum logic [1:0] {
        SHIFT_SLL = 2'd0,
        SHIFT_SRL = 2'd1,
        SHIFT_SRA = 2'd2
    } shift_op_e;

    // Element width, encoded as log2 of the element size in bytes
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    // Command, a num_beats of zero is illegal
    typedef struct packed {
        shift_op_e               op;
        sew_e                    sew;
        logic [BEAT_CNT_W-1:0]   num_beats;
    } cmd_t;

    // Input beat
    typedef struct packed {
        logic [DATA_WIDTH-1:0] srca;  // Data to shift
        logic [DATA_WIDTH-1:0] srcb;  // Per element shift amounts
    } beat_t;

    // Result beat
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;  // Final beat of the command
    } result_t;

    // Beat viewed as bytes, byte 0 is least significant
    typedef logic [VSHIFT_BYTES-1:0][BYTE_WIDTH-1:0] byte_vec_t;

endpackage : vshift_pkg

// ==== vshift_unit.sv ====
//******************************
// Vector shift unit top level
// Command, beat and result streams around
// the shift core
//******************************

module vshift_unit #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  vshift_pkg::cmd_t     cmd,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  vshift_pkg::beat_t    in_beat,
    output logic                 out_valid,
    input  logic                 out_ready,
    output vshift_pkg::result_t  out_result
);

    vshift_pkg::beat_t     issue_beat;
    vshift_pkg::result_t   shift_res;
    vshift_pkg::shift_op_e cur_op;
    vshift_pkg::sew_e      cur_sew;

    logic in_full;
    logic in_empty;
    logic out_full;
    logic out_empty;
    logic accept_beats;
    logic issue;
    logic load;
    logic last_beat;
    logic count_done;
    logic last_result_sent;

    assign in_ready         = ~in_full & accept_beats;
    assign out_valid        = ~out_empty;
    assign last_result_sent = out_valid & out_ready & out_result.last;
    assign shift_res.last   = last_beat;

    beat_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(vshift_pkg::beat_t)) u_in_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_valid & in_ready),
        .push_data (in_beat),
        .pop       (issue),
        .pop_data  (issue_beat),
        .full      (in_full),
        .empty     (in_empty)
    );

    vector_shifter u_shifter (
        .op     (cur_op),
        .sew    (cur_sew),
        .srca   (issue_beat.srca),
        .srcb   (issue_beat.srcb),
        .result (shift_res.data)
    );

    beat_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(vshift_pkg::result_t)) u_out_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (issue),
        .push_data (shift_res),
        .pop       (out_valid & out_ready),
        .pop_data  (out_result),
        .full      (out_full),
        .empty     (out_empty)
    );

    beat_counter u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .load_value (cmd.num_beats),
        .dec        (issue),
        .last_beat  (last_beat),
        .done       (count_done)
    );

    shift_ctrl_fsm u_fsm (
        .clk              (clk),
        .rst_n            (rst_n),
        .cmd_valid        (cmd_valid),
        .cmd_ready        (cmd_ready),
        .cmd              (cmd),
        .in_empty         (in_empty),
        .out_full         (out_full),
        .count_done       (count_done),
        .last_result_sent (last_result_sent),
        .accept_beats     (accept_beats),
        .issue            (issue),
        .load             (load),
        .cur_op           (cur_op),
        .cur_sew          (cur_sew)
    );

endmodule : vshift_unit
